//--- dv/fb_master_tests.txt
// Columns: kind_row_col_count_colour in hex, row and col in pixels
// Kind 1 pixel entry, 2 fill run, 3 bus error on write index, 4 final err_count
// Pixel entries ahead of the first fill
1_000_000_0000_ff0000ff
1_001_002_0000_00ff00ff
1_1df_27f_0000_12345678
1_0a0_140_0000_deadbeef
1_064_032_0000_0badf00d
// Fill of 8 pixels while the FIFO drains
2_0c8_000_0008_00112233
// More entries, then a fill that competes with them
1_005_005_0000_aaaa5555
1_010_020_0000_5555aaaa
1_07f_1ff_0000_c0ffee00
// Run crossing the end of row 201
2_0c9_27c_0006_44556677
// Empty run, done with no write
2_0d0_010_0000_99999999
2_0e0_100_0004_abcdef01
// Bus errors on writes 3, 11 and 20
3_000_000_0003_00000000
3_000_000_000b_00000000
3_000_000_0014_00000000
// Final error count
4_000_000_0003_00000000

//--- list.f
+incdir+common
common/fb_pkg.sv
fbwriter/fbwriter.sv
fbwriter/fb_filler.sv
rtl/mst_arbiter.sv
rtl/fb_master_top.sv
dv/fb_master_tb.sv

//--- Bender.yml
package:
  name: fb_master

sources:
  - include_dirs:
      - common
    files:
      - common/fb_pkg.sv
      - fbwriter/fbwriter.sv
      - fbwriter/fb_filler.sv
      - rtl/mst_arbiter.sv
      - rtl/fb_master_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/fb_master_tb.sv

//--- dv/fb_master_tb.sv
`include "fb_defs.svh"

module fb_master_tb;

	localparam int MAX_RECS = 64;

	logic                    PLB_clk;
	logic                    arst_n;
	fb_pkg::fifo_entry_t     fifo_data;
	logic                    fifo_empty;
	logic                    fifo_rd_en;
	logic                    fill_start;
	fb_pkg::fill_cmd_t       fill_cmd;
	logic                    fill_busy;
	logic                    fill_done;
	logic                    IP2Bus_MstWr_Req;
	fb_pkg::bus_addr_t       IP2Bus_Mst_Addr;
	logic [0:3]              IP2Bus_Mst_BE;
	fb_pkg::pixel_t          IP2Bus_MstWr_d;
	logic                    Bus2IP_Mst_CmdAck;
	logic                    Bus2IP_Mst_Cmplt;
	logic                    Bus2IP_Mst_Error;
	logic                    Bus2IP_Mst_Cmd_Timeout;
	logic [`FB_ERRCNT_W-1:0] err_count;

	// Records as kind, row, col, count, colour
	logic [75:0]             recs [0:MAX_RECS-1];
	logic                    err_mark [0:255];
	fb_pkg::fifo_entry_t     fifo_q [$];
	// Expected writes, one queue per engine
	fb_pkg::mst_cmd_t        fw_q [$];
	fb_pkg::mst_cmd_t        fl_q [$];
	logic                    pop_req;
	logic                    fifo_open;
	int                      n_writes;
	int                      exp_err;
	int                      cycle_limit;
	int                      cycles;
	int                      cmplt_cnt;
	int                      err_model;
	int                      fills_issued;
	int                      fills_seen;
	// Bus history from the previous cycle
	logic                    prev_req;
	logic                    prev_ack;
	logic                    prev_both;
	fb_pkg::bus_addr_t       prev_addr;
	logic                    tie;
	logic                    pending;
	logic                    last_fill;

	fb_master_top i_fb_master_top (.*);

	initial
	begin
		PLB_clk = 1'b0;
		forever #4 PLB_clk = ~PLB_clk;
	end

	////////////////////////////////////////////////////////////
	// Checks and expected values
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// Row major, one word per pixel, steps run on across rows
	function automatic logic [31:0] word_addr(input int row, input int col, input int step);
		return `FB_BASE_ADDR + ((row * `FB_XRES + col + step) * 4);
	endfunction

	// Write taken on CmdAck, owner found from the queue heads
	task automatic accept_write();
		fb_pkg::mst_cmd_t exp_cmd;
		logic             is_fill;
		if ((fw_q.size() == 0) && (fl_q.size() == 0))
		begin
			$display("Bus write at %0t with no write left to expect", $time);
			stop_run();
		end
		else
		begin
			is_fill = (fw_q.size() == 0) ||
				((fw_q[0].addr != IP2Bus_Mst_Addr) && (fl_q.size() != 0));
			exp_cmd = is_fill ? fl_q.pop_front() : fw_q.pop_front();
			compare(IP2Bus_Mst_Addr, exp_cmd.addr, "write address");
			compare(IP2Bus_MstWr_d, exp_cmd.data, "write data");
			compare(IP2Bus_Mst_BE, 4'hf, "byte enables");
			// Same winner twice while the other waited
			if (tie && (is_fill == last_fill))
			begin
				$display("Engine granted twice in a row while the other was waiting");
				stop_run();
			end
			last_fill = is_fill;
		end
	endtask

	task automatic watch_bus();
		if (fifo_rd_en && fifo_empty)
		begin
			$display("FIFO popped while empty at %0t", $time);
			stop_run();
		end
		if (fifo_rd_en)
		begin
			pop_req = 1'b1;
		end
		compare(err_count, err_model, "err_count");
		// Request and address held until acknowledge
		if (prev_req && !prev_ack)
		begin
			compare(IP2Bus_MstWr_Req, 1'b1, "request dropped before CmdAck");
			compare(IP2Bus_Mst_Addr, prev_addr, "address changed before CmdAck");
		end
		if (IP2Bus_MstWr_Req && pending)
		begin
			$display("New bus request before the previous write completed");
			stop_run();
		end
		// Grant was made in the cycle before the request rose
		if (IP2Bus_MstWr_Req && !prev_req)
		begin
			tie = prev_both;
		end
		if (IP2Bus_MstWr_Req && Bus2IP_Mst_CmdAck)
		begin
			accept_write();
			pending = 1'b1;
		end
		if (Bus2IP_Mst_Cmplt)
		begin
			pending = 1'b0;
			cmplt_cnt++;
			if (Bus2IP_Mst_Error)
			begin
				err_model++;
			end
		end
		if (fill_done)
		begin
			fills_seen++;
			compare(fl_q.size(), 0, "fill writes left at fill_done");
			compare(fill_busy, 1'b0, "fill_busy at fill_done");
			compare(fills_seen <= fills_issued, 1'b1, "extra fill_done pulse");
		end
		prev_req  = IP2Bus_MstWr_Req;
		prev_ack  = Bus2IP_Mst_CmdAck;
		prev_addr = IP2Bus_Mst_Addr;
		prev_both = i_fb_master_top.fw_req && i_fb_master_top.fl_req;
	endtask

	// Outputs sampled mid cycle where they are settled
	always @(negedge PLB_clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the writes did not all finish", cycle_limit);
			stop_run();
		end
		else if (arst_n)
		begin
			watch_bus();
		end
	end

	////////////////////////////////////////////////////////////
	// FIFO model and bus responder
	////////////////////////////////////////////////////////////

	// Head word shown ahead of the pop, FWFT style
	always @(posedge PLB_clk)
	begin
		#1;
		if (pop_req)
		begin
			void'(fifo_q.pop_front());
			pop_req = 1'b0;
		end
		fifo_empty = !fifo_open || (fifo_q.size() == 0);
		if (fifo_q.size() != 0)
		begin
			fifo_data = fifo_q[0];
		end
	end

	// CmdAck after 0 to 3 cycles, Cmplt 0 to 3 cycles after that
	initial
	begin
		int d_ack;
		int d_cmplt;
		int wr_idx;
		void'($urandom(84634));
		wr_idx = 0;
		forever
		begin
			@(negedge PLB_clk);
			if (IP2Bus_MstWr_Req)
			begin
				d_ack   = $urandom_range(3);
				d_cmplt = $urandom_range(3);
				repeat (d_ack) @(posedge PLB_clk);
				@(posedge PLB_clk);
				#1;
				Bus2IP_Mst_CmdAck = 1'b1;
				repeat (d_cmplt)
				begin
					@(posedge PLB_clk);
					#1;
					Bus2IP_Mst_CmdAck = 1'b0;
				end
				Bus2IP_Mst_Cmplt = 1'b1;
				Bus2IP_Mst_Error = err_mark[wr_idx];
				@(posedge PLB_clk);
				#1;
				Bus2IP_Mst_CmdAck = 1'b0;
				Bus2IP_Mst_Cmplt  = 1'b0;
				Bus2IP_Mst_Error  = 1'b0;
				wr_idx++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		fb_pkg::fifo_entry_t ent;
		fb_pkg::mst_cmd_t    wr;
		logic [75:0]         r;
		int                  i;
		int                  k;
		arst_n                 = 1'b0;
		fifo_data              = '0;
		fifo_empty             = 1'b1;
		fill_start             = 1'b0;
		fill_cmd               = '0;
		Bus2IP_Mst_CmdAck      = 1'b0;
		Bus2IP_Mst_Cmplt       = 1'b0;
		Bus2IP_Mst_Error       = 1'b0;
		Bus2IP_Mst_Cmd_Timeout = 1'b0;
		pop_req      = 1'b0;
		fifo_open    = 1'b0;
		n_writes     = 0;
		exp_err      = 0;
		cycles       = 0;
		cmplt_cnt    = 0;
		err_model    = 0;
		fills_issued = 0;
		fills_seen   = 0;
		prev_req     = 1'b0;
		prev_ack     = 1'b0;
		prev_both    = 1'b0;
		prev_addr    = '0;
		tie          = 1'b0;
		pending      = 1'b0;
		// Pixel writer wins the first tie
		last_fill    = 1'b1;
		for (i = 0; i < MAX_RECS; i++)
		begin
			recs[i] = '0;
		end
		for (i = 0; i < 256; i++)
		begin
			err_mark[i] = 1'b0;
		end
		$readmemh("dv/fb_master_tests.txt", recs);
		// Write count, error marks and final count up front
		for (i = 0; (i < MAX_RECS) && (recs[i][75:72] != 4'd0); i++)
		begin
			r = recs[i];
			case (r[75:72])
				4'd1: n_writes += 1;
				4'd2: n_writes += int'(r[47:32]);
				4'd3: err_mark[r[39:32]] = 1'b1;
				4'd4: exp_err = int'(r[47:32]);
				default: ;
			endcase
		end
		cycle_limit = 40 * n_writes + 200;

		// Reset values checked while reset is still low
		repeat (16) @(negedge PLB_clk);
		compare(fifo_rd_en, 1'b0, "fifo_rd_en in reset");
		compare(IP2Bus_MstWr_Req, 1'b0, "IP2Bus_MstWr_Req in reset");
		compare(fill_done, 1'b0, "fill_done in reset");
		compare(err_count, 0, "err_count in reset");
		@(posedge PLB_clk);
		#1;
		arst_n = 1'b1;
		@(posedge PLB_clk);
		#2;
		fifo_open = 1'b1;

		for (i = 0; (i < MAX_RECS) && (recs[i][75:72] != 4'd0); i++)
		begin
			r = recs[i];
			if (r[75:72] == 4'd1)
			begin
				@(posedge PLB_clk);
				#2;
				ent        = '0;
				ent.row    = r[68:60];
				ent.col    = r[57:48];
				ent.colour = r[31:0];
				fifo_q.push_back(ent);
				wr.addr = word_addr(int'(r[71:60]), int'(r[59:48]), 0);
				wr.data = r[31:0];
				fw_q.push_back(wr);
			end
			else if (r[75:72] == 4'd2)
			begin
				@(posedge PLB_clk);
				#1;
				fill_cmd.row    = r[68:60];
				fill_cmd.col    = r[57:48];
				fill_cmd.count  = r[47:32];
				fill_cmd.colour = r[31:0];
				fill_start      = 1'b1;
				for (k = 0; k < int'(r[47:32]); k++)
				begin
					wr.addr = word_addr(int'(r[71:60]), int'(r[59:48]), k);
					wr.data = r[31:0];
					fl_q.push_back(wr);
				end
				fills_issued++;
				@(posedge PLB_clk);
				#1;
				fill_start = 1'b0;
				while (fills_seen < fills_issued)
				begin
					@(posedge PLB_clk);
				end
			end
		end

		while ((cmplt_cnt < n_writes) || (fifo_q.size() != 0))
		begin
			@(posedge PLB_clk);
		end
		repeat (3) @(negedge PLB_clk);
		compare(fw_q.size(), 0, "pixel writes never seen");
		compare(fl_q.size(), 0, "fill writes never seen");
		compare(cmplt_cnt, n_writes, "completed writes");
		compare(err_count, exp_err, "final err_count");
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- rtl/fb_master_top.sv
`include "fb_defs.svh"

module fb_master_top
(
	input  logic                          PLB_clk,
	input  logic                          arst_n,

	// Pixel FIFO
	input  fb_pkg::fifo_entry_t           fifo_data,
	input  logic                          fifo_empty,
	output logic                          fifo_rd_en,

	// Fill control
	input  logic                          fill_start,
	input  fb_pkg::fill_cmd_t             fill_cmd,
	output logic                          fill_busy,
	output logic                          fill_done,

	// IPIF master write port
	output logic                          IP2Bus_MstWr_Req,
	output fb_pkg::bus_addr_t             IP2Bus_Mst_Addr,
	output logic [0:3]                    IP2Bus_Mst_BE,
	output fb_pkg::pixel_t                IP2Bus_MstWr_d,
	input  logic                          Bus2IP_Mst_CmdAck,
	input  logic                          Bus2IP_Mst_Cmplt,
	input  logic                          Bus2IP_Mst_Error,
	input  logic                          Bus2IP_Mst_Cmd_Timeout,

	output logic [`FB_ERRCNT_W-1:0]       err_count
);

	// Pixel writer to arbiter
	logic             fw_req;
	logic             fw_done;
	fb_pkg::mst_cmd_t fw_cmd;
	// Filler to arbiter
	logic             fl_req;
	logic             fl_done;
	fb_pkg::mst_cmd_t fl_cmd;

	////////////////////////////////////////////////////////////
	// Engines
	////////////////////////////////////////////////////////////

	fbwriter i_fbwriter (
		.PLB_clk    (PLB_clk),
		.arst_n     (arst_n),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty),
		.fifo_rd_en (fifo_rd_en),
		.wr_req     (fw_req),
		.cmd        (fw_cmd),
		.wr_done    (fw_done)
	);

	fb_filler i_fb_filler (
		.PLB_clk    (PLB_clk),
		.arst_n     (arst_n),
		.fill_start (fill_start),
		.fill_cmd   (fill_cmd),
		.fill_busy  (fill_busy),
		.fill_done  (fill_done),
		.wr_req     (fl_req),
		.cmd        (fl_cmd),
		.wr_done    (fl_done)
	);

	// Pixel writer on port A, filler on port B
	mst_arbiter i_mst_arbiter (
		.PLB_clk                (PLB_clk),
		.arst_n                 (arst_n),
		.req_a                  (fw_req),
		.cmd_a                  (fw_cmd),
		.done_a                 (fw_done),
		.req_b                  (fl_req),
		.cmd_b                  (fl_cmd),
		.done_b                 (fl_done),
		.IP2Bus_MstWr_Req       (IP2Bus_MstWr_Req),
		.IP2Bus_Mst_Addr        (IP2Bus_Mst_Addr),
		.IP2Bus_Mst_BE          (IP2Bus_Mst_BE),
		.IP2Bus_MstWr_d         (IP2Bus_MstWr_d),
		.Bus2IP_Mst_CmdAck      (Bus2IP_Mst_CmdAck),
		.Bus2IP_Mst_Cmplt       (Bus2IP_Mst_Cmplt),
		.Bus2IP_Mst_Error       (Bus2IP_Mst_Error),
		.Bus2IP_Mst_Cmd_Timeout (Bus2IP_Mst_Cmd_Timeout),
		.err_count              (err_count)
	);

endmodule

//--- rtl/mst_arbiter.sv
`include "fb_defs.svh"

module mst_arbiter
(
	input  logic                          PLB_clk,
	input  logic                          arst_n,

	// Engine A, pixel writer
	input  logic                          req_a,
	input  fb_pkg::mst_cmd_t              cmd_a,
	output logic                          done_a,
	// Engine B, filler
	input  logic                          req_b,
	input  fb_pkg::mst_cmd_t              cmd_b,
	output logic                          done_b,

	// IPIF master write command
	output logic                          IP2Bus_MstWr_Req,
	output fb_pkg::bus_addr_t             IP2Bus_Mst_Addr,
	output logic [0:3]                    IP2Bus_Mst_BE,
	output fb_pkg::pixel_t                IP2Bus_MstWr_d,
	input  logic                          Bus2IP_Mst_CmdAck,
	input  logic                          Bus2IP_Mst_Cmplt,
	input  logic                          Bus2IP_Mst_Error,
	input  logic                          Bus2IP_Mst_Cmd_Timeout,

	output logic [`FB_ERRCNT_W-1:0]       err_count
);

	fb_pkg::arb_state_t state;
	fb_pkg::mst_cmd_t   cmd_q;
	logic               gnt_b;
	logic               pick_b;
	logic               cmplt_hit;

	////////////////////////////////////////////////////////////
	// Grant
	////////////////////////////////////////////////////////////

	// On a tie the engine not granted last wins
	assign pick_b = (req_a && req_b) ? ~gnt_b : req_b;

	// Completion may also land in the acknowledge cycle
	assign cmplt_hit = Bus2IP_Mst_Cmplt &&
		((state == fb_pkg::arb_wait_cmplt) ||
		 ((state == fb_pkg::arb_request) && Bus2IP_Mst_CmdAck));

	assign done_a = cmplt_hit && !gnt_b;
	assign done_b = cmplt_hit && gnt_b;

	always_ff @(posedge PLB_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= fb_pkg::arb_idle;
			// Pixel writer gets the first tie
			gnt_b <= 1'b1;
		end
		else
		begin
			case (state)
				fb_pkg::arb_idle:
				begin
					if (req_a || req_b)
					begin
						gnt_b <= pick_b;
						state <= fb_pkg::arb_request;
					end
				end
				fb_pkg::arb_request:
				begin
					if (cmplt_hit)
					begin
						state <= fb_pkg::arb_idle;
					end
					else if (Bus2IP_Mst_CmdAck)
					begin
						state <= fb_pkg::arb_wait_cmplt;
					end
				end
				fb_pkg::arb_wait_cmplt:
				begin
					if (cmplt_hit)
					begin
						state <= fb_pkg::arb_idle;
					end
				end
				default:
				begin
					state <= fb_pkg::arb_idle;
				end
			endcase
		end
	end

	// Granted command captured at grant time
	always_ff @(posedge PLB_clk)
	begin
		if ((state == fb_pkg::arb_idle) && (req_a || req_b))
		begin
			cmd_q <= pick_b ? cmd_b : cmd_a;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus side
	////////////////////////////////////////////////////////////

	// Request held until CmdAck, data goes with it
	assign IP2Bus_MstWr_Req = (state == fb_pkg::arb_request);
	assign IP2Bus_Mst_Addr  = cmd_q.addr;
	assign IP2Bus_MstWr_d   = cmd_q.data;
	assign IP2Bus_Mst_BE    = `FB_BE_ALL;

	// Failed writes counted, never retried
	always_ff @(posedge PLB_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			err_count <= '0;
		end
		else if (cmplt_hit && (Bus2IP_Mst_Error || Bus2IP_Mst_Cmd_Timeout) &&
			(err_count != '1))
		begin
			err_count <= err_count + 1'b1;
		end
	end

	// One done per completion, then none until the next one
	a_one_done: assert property (@(posedge PLB_clk) disable iff (!arst_n)
		Bus2IP_Mst_Cmplt && (state != fb_pkg::arb_idle)
		|-> $onehot({done_a, done_b}) ##1 !(done_a || done_b));

endmodule

//--- fbwriter/fb_filler.sv
`include "fb_defs.svh"

module fb_filler
(
	input  logic              PLB_clk,
	input  logic              arst_n,

	input  logic              fill_start,
	input  fb_pkg::fill_cmd_t fill_cmd,
	output logic              fill_busy,
	output logic              fill_done,

	// Toward the arbiter
	output logic              wr_req,
	output fb_pkg::mst_cmd_t  cmd,
	input  logic              wr_done
);

	logic [0:15]       remaining;
	fb_pkg::bus_addr_t addr_q;
	fb_pkg::pixel_t    colour_q;

	// One request per remaining pixel
	assign wr_req   = fill_busy;
	assign cmd.addr = addr_q;
	assign cmd.data = colour_q;

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////

	always_ff @(posedge PLB_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fill_busy <= 1'b0;
			fill_done <= 1'b0;
			remaining <= '0;
		end
		else
		begin
			fill_done <= 1'b0;
			if (fill_start)
			begin
				// Empty run finishes at once
				fill_busy <= (fill_cmd.count != 16'd0);
				fill_done <= (fill_cmd.count == 16'd0);
				remaining <= fill_cmd.count;
			end
			else if (wr_done)
			begin
				remaining <= remaining - 16'd1;
				// Last pixel retired
				if (remaining == 16'd1)
				begin
					fill_busy <= 1'b0;
					fill_done <= 1'b1;
				end
			end
		end
	end

	// Start address once, then one word per write
	always_ff @(posedge PLB_clk)
	begin
		if (fill_start)
		begin
			addr_q   <= fb_pkg::pixel_addr(fill_cmd.row, fill_cmd.col);
			colour_q <= fill_cmd.colour;
		end
		else if (wr_done)
		begin
			addr_q <= addr_q + 32'd4;
		end
	end

	// New run only when idle, starting inside the visible area
	a_start_idle: assert property (@(posedge PLB_clk) disable iff (!arst_n)
		fill_start |-> !fill_busy && (fill_cmd.row < `FB_YRES) && (fill_cmd.col < `FB_XRES));

endmodule

//--- fbwriter/fbwriter.sv
module fbwriter
(
	input  logic                PLB_clk,
	input  logic                arst_n,

	// FWFT FIFO read side
	input  fb_pkg::fifo_entry_t fifo_data,
	input  logic                fifo_empty,
	output logic                fifo_rd_en,

	// Toward the arbiter
	output logic                wr_req,
	output fb_pkg::mst_cmd_t    cmd,
	input  logic                wr_done
);

	typedef enum logic {
		wr_idle,
		wr_pending
	} wr_state_t;

	wr_state_t state;

	////////////////////////////////////////////////////////////
	// Pop and request
	////////////////////////////////////////////////////////////

	// Head word is already valid on an FWFT FIFO
	// so the pop and the latch share one cycle
	assign fifo_rd_en = (state == wr_idle) && !fifo_empty;

	// Request level follows the pending state
	assign wr_req = (state == wr_pending);

	always_ff @(posedge PLB_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= wr_idle;
		end
		else
		begin
			case (state)
				wr_idle:
				begin
					if (fifo_rd_en)
					begin
						state <= wr_pending;
					end
				end
				wr_pending:
				begin
					// Back to idle, next pop no earlier than next cycle
					if (wr_done)
					begin
						state <= wr_idle;
					end
				end
				default:
				begin
					state <= wr_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Command payload
	////////////////////////////////////////////////////////////

	// Address from row and column, colour goes out unchanged
	always_ff @(posedge PLB_clk)
	begin
		if (fifo_rd_en)
		begin
			cmd.addr <= fb_pkg::pixel_addr(fifo_data.row, fifo_data.col);
			cmd.data <= fifo_data.colour;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Pop only from a non-empty FIFO, and a request follows it
	a_pop_then_req: assert property (@(posedge PLB_clk) disable iff (!arst_n)
		fifo_rd_en |-> !fifo_empty ##1 wr_req);

	// Command held until the arbiter retires it
	a_cmd_stable: assert property (@(posedge PLB_clk) disable iff (!arst_n)
		wr_req && !wr_done |=> wr_req && $stable(cmd));

endmodule

//--- common/fb_pkg.sv
package fb_pkg;

	`include "fb_defs.svh"

	////////////////////////////////////////////////////////////
	// Basic widths, bus vectors numbered MSB first
	////////////////////////////////////////////////////////////

	typedef logic [0:31] bus_addr_t;
	typedef logic [0:31] pixel_t;
	typedef logic [0:8]  row_t;
	typedef logic [0:9]  col_t;

	// FIFO word as packed by the producer side
	typedef struct packed {
		logic [0:6] pad_hi;
		row_t       row;
		logic [0:5] pad_lo;
		col_t       col;
		pixel_t     colour;
	} fifo_entry_t;

	// One pending single-beat write
	typedef struct packed {
		bus_addr_t addr;
		pixel_t    data;
	} mst_cmd_t;

	// Run fill request, count of zero is legal
	typedef struct packed {
		row_t        row;
		col_t        col;
		logic [0:15] count;
		pixel_t      colour;
	} fill_cmd_t;

	typedef enum logic [1:0] {
		arb_idle,
		arb_request,
		arb_wait_cmplt
	} arb_state_t;

	// Word address of a pixel, row major
	function automatic bus_addr_t pixel_addr(row_t row, col_t col);
		logic [31:0] idx;
		idx = 32'(row) * `FB_XRES + 32'(col);
		return `FB_BASE_ADDR + (idx << 2);
	endfunction

endpackage

//--- common/fb_defs.svh
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

////////////////////////////////////////////////////////////
// Framebuffer geometry
////////////////////////////////////////////////////////////

// Visible pixels per row
`define FB_XRES 640
// Visible rows
`define FB_YRES 480

// Byte address of pixel (0,0), one 32-bit word per pixel
`define FB_BASE_ADDR 32'h0100_0000

// Saturating error counter width
`define FB_ERRCNT_W 8
// Single-beat word write, every byte lane on
`define FB_BE_ALL 4'b1111

`endif
